// File: hw/vsaPkg.sv
`default_nettype none

package vsaPkg;

    // datapath widths
    localparam int dataWidth   = 5;  // registers, alu, data bus
    localparam int pcWidth     = 5;  // instruction address
    localparam int instrWidth  = 12;
    localparam int regIdxWidth = 2;
    localparam int opWidth     = 3;
    localparam int funcWidth   = 3;

    typedef logic [dataWidth-1:0]   dataWord;     // register value, alu result, data addr
    typedef logic [pcWidth-1:0]     pcWord;
    typedef logic [instrWidth-1:0]  instrWord;
    typedef logic [regIdxWidth-1:0] regIndex;
    typedef logic [opWidth-1:0]     opcodeField;
    typedef logic [funcWidth-1:0]   funcField;

    // one instruction walks through all five phases
    typedef enum logic [2:0] {
        phaseIf  = 3'd0,  // fetch
        phaseId  = 3'd1,  // decode, operand read
        phaseEx  = 3'd2,  // alu
        phaseMem = 3'd3,  // data access, pc update
        phaseWb  = 3'd4   // register write
    } phaseState;

    // opcodes, instr[11:9]
    localparam opcodeField opLw   = 3'd0;
    localparam opcodeField opSw   = 3'd1;
    localparam opcodeField opBeqz = 3'd2;
    localparam opcodeField opAlu  = 3'd3;  // r-format, function in instr[2:0]
    localparam opcodeField opAddi = 3'd4;
    localparam opcodeField opSubi = 3'd5;

    // alu function codes for opAlu
    localparam funcField fnAdd = 3'd0;
    localparam funcField fnSub = 3'd1;
    localparam funcField fnAnd = 3'd2;
    localparam funcField fnOr  = 3'd3;
    localparam funcField fnXor = 3'd4;
    localparam funcField fnNot = 3'd5;  // ignores opB
    localparam funcField fnSrl = 3'd6;  // shift by one
    localparam funcField fnSra = 3'd7;

    // instruction words sit two addresses apart
    localparam pcWord pcStep = 5'd2;

    // r0 reads as zero, r1..r3 writable
    localparam int numRegs = 4;

    // instruction field layout
    //   r-format: op(3) src1(2) src2(2) dst(2) func(3)
    //   i-format: op(3) src1(2) dst(2)  imm(5)
    // src2 and the i-format dst share bits 6:5

endpackage

`default_nettype wire

// File: hw/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire vsaPkg::instrWord  instruction,  // from instruction memory
    input  wire logic              redirect,     // taken branch, valid in phaseMem
    input  wire vsaPkg::pcWord     target,       // branch destination
    output vsaPkg::phaseState      phase,
    output vsaPkg::pcWord          pc,
    output vsaPkg::pcWord          npc,
    output vsaPkg::instrWord       ir
);

    vsaPkg::phaseState nextPhase;
    vsaPkg::pcWord     nextPc;

    // fixed five step rotation, no stalls
    always_comb begin
        case (phase)
            vsaPkg::phaseIf:  nextPhase = vsaPkg::phaseId;
            vsaPkg::phaseId:  nextPhase = vsaPkg::phaseEx;
            vsaPkg::phaseEx:  nextPhase = vsaPkg::phaseMem;
            vsaPkg::phaseMem: nextPhase = vsaPkg::phaseWb;
            vsaPkg::phaseWb:  nextPhase = vsaPkg::phaseIf;
            default:          nextPhase = vsaPkg::phaseIf;  // unused encodings recover
        endcase
    end

    // taken branch wins over sequential flow
    assign nextPc = redirect ? target : npc;

    always_ff @(posedge clock) begin
        if (reset) begin
            phase <= vsaPkg::phaseIf;
            pc    <= '0;
            npc   <= '0;
            ir    <= '0;
        end else begin
            phase <= nextPhase;

            // memory answers combinationally at pc
            if (phase == vsaPkg::phaseIf) begin
                ir  <= instruction;
                npc <= pc + vsaPkg::pcStep;  // wraps at 32
            end

            // pc moves only here, once per instruction
            if (phase == vsaPkg::phaseMem) begin
                pc <= nextPc;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire vsaPkg::phaseState phase,
    input  wire vsaPkg::instrWord  ir,
    input  wire vsaPkg::dataWord   aluResult,  // registered alu output
    input  wire vsaPkg::dataWord   loadData,   // latched load word
    output vsaPkg::dataWord        opA,
    output vsaPkg::dataWord        opB
);

    vsaPkg::opcodeField opcode;
    vsaPkg::regIndex    src1;
    vsaPkg::regIndex    src2;     // also i-format destination
    vsaPkg::regIndex    dst;      // r-format destination
    vsaPkg::dataWord    readA;
    vsaPkg::dataWord    readB;
    logic               wbEnable;
    vsaPkg::regIndex    wbIndex;
    vsaPkg::dataWord    wbData;

    vsaPkg::dataWord regFile [vsaPkg::numRegs];

    // field slicing
    assign opcode = vsaPkg::opcodeField'(ir[11:9]);
    assign src1   = ir[8:7];
    assign src2   = ir[6:5];
    assign dst    = ir[4:3];

    // r0 always reads zero
    assign readA = (src1 == '0) ? '0 : regFile[src1];
    assign readB = (src2 == '0) ? '0 : regFile[src2];

    // write-back select by instruction class
    always_comb begin
        wbEnable = 1'b0;
        wbIndex  = src2;       // i-format destination by default
        wbData   = aluResult;
        case (opcode)
            vsaPkg::opAlu: begin
                wbEnable = 1'b1;
                wbIndex  = dst;
            end
            vsaPkg::opAddi, vsaPkg::opSubi: begin
                wbEnable = 1'b1;
            end
            vsaPkg::opLw: begin
                wbEnable = 1'b1;
                wbData   = loadData;
            end
            default: wbEnable = 1'b0;  // sw, beqz write nothing
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            regFile <= '{default: '0};
            opA     <= '0;
            opB     <= '0;
        end else begin
            if (phase == vsaPkg::phaseId) begin
                opA <= readA;
                opB <= readB;  // also store data
            end
            // writes to r0 dropped
            if (phase == vsaPkg::phaseWb && wbEnable && wbIndex != '0) begin
                regFile[wbIndex] <= wbData;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire vsaPkg::phaseState phase,
    input  wire vsaPkg::instrWord  ir,
    input  wire vsaPkg::pcWord     npc,   // pc + 2 of this instruction
    input  wire vsaPkg::dataWord   opA,
    input  wire vsaPkg::dataWord   opB,
    output vsaPkg::dataWord        aluResult,
    output logic                   cond   // beqz test, opA == 0
);

    vsaPkg::opcodeField opcode;
    vsaPkg::funcField   func;
    vsaPkg::dataWord    imm;       // unsigned, no sign extension
    vsaPkg::dataWord    funcOut;
    vsaPkg::dataWord    aluNext;

    assign opcode = vsaPkg::opcodeField'(ir[11:9]);
    assign func   = vsaPkg::funcField'(ir[2:0]);
    assign imm    = ir[4:0];

    // r-format function unit
    always_comb begin
        case (func)
            vsaPkg::fnAdd: funcOut = opA + opB;
            vsaPkg::fnSub: funcOut = opA - opB;
            vsaPkg::fnAnd: funcOut = opA & opB;
            vsaPkg::fnOr:  funcOut = opA | opB;
            vsaPkg::fnXor: funcOut = opA ^ opB;
            vsaPkg::fnNot: funcOut = ~opA;
            vsaPkg::fnSrl: funcOut = {1'b0, opA[4:1]};
            vsaPkg::fnSra: funcOut = {opA[4], opA[4:1]};  // keep sign bit
            default:       funcOut = '0;
        endcase
    end

    // result by instruction class
    always_comb begin
        case (opcode)
            vsaPkg::opLw, vsaPkg::opSw: aluNext = opA + imm;  // data address
            vsaPkg::opAlu:              aluNext = funcOut;
            vsaPkg::opAddi:             aluNext = opA + imm;
            vsaPkg::opSubi:             aluNext = opA - imm;
            // word offset, low four bits doubled
            vsaPkg::opBeqz:             aluNext = npc + {imm[3:0], 1'b0};
            default:                    aluNext = aluResult;  // opcodes 6, 7 hold
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            aluResult <= '0;
            cond      <= 1'b0;
        end else if (phase == vsaPkg::phaseEx) begin
            aluResult <= aluNext;
            if (opcode == vsaPkg::opBeqz) begin
                cond <= (opA == '0);
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/memoryStage.sv
`timescale 1ns/1ps
`default_nettype none

module memoryStage (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire vsaPkg::phaseState phase,
    input  wire vsaPkg::instrWord  ir,
    input  wire logic              cond,
    input  wire vsaPkg::dataWord   aluResult,  // data address or branch target
    input  wire vsaPkg::dataWord   dataIn,     // data memory read port
    output vsaPkg::dataWord        loadData,
    output logic                   wr,
    output logic                   redirect,
    output vsaPkg::pcWord          target
);

    vsaPkg::opcodeField opcode;
    logic               inMem;
    logic               isLoad;
    logic               isStore;
    logic               isBranch;

    assign opcode   = vsaPkg::opcodeField'(ir[11:9]);
    assign inMem    = (phase == vsaPkg::phaseMem);
    assign isLoad   = (opcode == vsaPkg::opLw);
    assign isStore  = (opcode == vsaPkg::opSw);
    assign isBranch = (opcode == vsaPkg::opBeqz);

    // strobe spans the whole memory cycle, write on its closing edge
    assign wr = inMem && isStore;

    // taken beqz steers the pc update at end of phaseMem
    assign redirect = inMem && isBranch && cond;
    assign target   = vsaPkg::pcWord'(aluResult);

    always_ff @(posedge clock) begin
        if (reset) begin
            loadData <= '0;
        end else if (inMem && isLoad) begin
            loadData <= dataIn;  // consumed in phaseWb
        end
    end

endmodule

`default_nettype wire

// File: hw/vsaCore.sv
`timescale 1ns/1ps
`default_nettype none

module vsaCore (
    input  wire logic              clock,
    input  wire logic              reset,
    output vsaPkg::pcWord          pc,           // instruction memory address
    input  wire vsaPkg::instrWord  instruction,  // instruction memory data
    output vsaPkg::dataWord        aluOutput,    // data memory address
    input  wire vsaPkg::dataWord   dataIn,       // data memory read
    output vsaPkg::dataWord        dataOut,      // data memory write
    output logic                   wr            // data memory write strobe
);

    // stage to stage nets
    vsaPkg::phaseState phase;
    vsaPkg::pcWord     npc;
    vsaPkg::instrWord  ir;
    vsaPkg::dataWord   opA;
    vsaPkg::dataWord   opB;
    vsaPkg::dataWord   aluResult;
    logic              cond;
    vsaPkg::dataWord   loadData;
    logic              redirect;
    vsaPkg::pcWord     target;

    // phase owner, pc and ir
    fetchStage i_fetch (
        .clock       (clock),
        .reset       (reset),
        .instruction (instruction),
        .redirect    (redirect),
        .target      (target),
        .phase       (phase),
        .pc          (pc),
        .npc         (npc),
        .ir          (ir)
    );

    // register file, operands, write-back
    decodeStage i_decode (
        .clock     (clock),
        .reset     (reset),
        .phase     (phase),
        .ir        (ir),
        .aluResult (aluResult),
        .loadData  (loadData),
        .opA       (opA),
        .opB       (opB)
    );

    executeStage i_execute (
        .clock     (clock),
        .reset     (reset),
        .phase     (phase),
        .ir        (ir),
        .npc       (npc),
        .opA       (opA),
        .opB       (opB),
        .aluResult (aluResult),
        .cond      (cond)
    );

    // data access and branch decision
    memoryStage i_memory (
        .clock     (clock),
        .reset     (reset),
        .phase     (phase),
        .ir        (ir),
        .cond      (cond),
        .aluResult (aluResult),
        .dataIn    (dataIn),
        .loadData  (loadData),
        .wr        (wr),
        .redirect  (redirect),
        .target    (target)
    );

    assign aluOutput = aluResult;  // address held from phaseEx on
    assign dataOut   = opB;        // store data, always driven

endmodule

`default_nettype wire

// File: tests/vsaTestTasks.svh
`ifndef VSA_TEST_TASKS_SVH
`define VSA_TEST_TASKS_SVH

// r-format fields op src1 src2 dst func
function automatic vsaPkg::instrWord encodeR(input vsaPkg::regIndex src1,
        input vsaPkg::regIndex src2, input vsaPkg::regIndex dst, input vsaPkg::funcField fn);
    return {vsaPkg::opAlu, src1, src2, dst, fn};
endfunction

// i-format fields op src1 dst imm
// sw stores the register named in dst
function automatic vsaPkg::instrWord encodeI(input vsaPkg::opcodeField op,
        input vsaPkg::regIndex src1, input vsaPkg::regIndex dst, input vsaPkg::dataWord imm);
    return {op, src1, dst, imm};
endfunction

function automatic vsaPkg::dataWord randomWord();
    return vsaPkg::dataWord'($urandom);
endfunction

task automatic checkData(input string what, input vsaPkg::dataWord got,
        input vsaPkg::dataWord want);
    if (got !== want) begin
        errorCount++;
        $display("[FAIL] %0d ns: %s is %0d, expected %0d", $time, what, got, want);
    end
endtask

task automatic checkPc(input string what, input vsaPkg::pcWord got, input vsaPkg::pcWord want);
    if (got !== want) begin
        errorCount++;
        $display("[FAIL] %0d ns: %s is %0d, expected %0d", $time, what, got, want);
    end
endtask

task automatic checkStrobe(input string what, input logic got, input logic want);
    if (got !== want) begin
        errorCount++;
        $display("[FAIL] %0d ns: %s is %b, expected %b", $time, what, got, want);
    end
endtask

// empty slots read as a harmless lw r0
task automatic clearMemories();
    for (int a = 0; a < 32; a++) begin
        instrMem[a] = '0;
        dataMem[a]  = vsaPkg::dataWord'(a) ^ 5'h15;  // address pattern
    end
endtask

// core held in reset while memories are rewritten
task automatic beginProgram();
    @(posedge clock);
    #driveDelay reset = 1'b1;
    clearMemories();
    progLen = 0;
endtask

task automatic emit(input vsaPkg::instrWord word);
    instrMem[progLen * vsaPkg::pcStep] = word;
    progLen++;
endtask

// afterwards the current cycle is phaseIf at pc 0
task automatic releaseCore();
    repeat (resetCycles) @(posedge clock);
    #driveDelay reset = 1'b0;
endtask

task automatic runProgram();
    releaseCore();
    repeat (progLen * cyclesPerInstr) @(posedge clock);  // five cycles per instruction
    #driveDelay;
endtask

task automatic reportTest(input string name);
    testsRun++;
    if (errorCount == lastErrorCount) begin
        $display("%s: ok", name);
    end else begin
        testsFailed++;
        $display("%s: %0d mismatches", name, errorCount - lastErrorCount);
    end
    lastErrorCount = errorCount;
endtask

task automatic testLoadStore();
    vsaPkg::dataWord words [3];
    beginProgram();
    for (int i = 0; i < 3; i++) begin
        words[i]        = randomWord();
        dataMem[20 + i] = words[i];
        emit(encodeI(vsaPkg::opLw, 2'd0, vsaPkg::regIndex'(i + 1), vsaPkg::dataWord'(20 + i)));
    end
    for (int i = 0; i < 3; i++) begin
        emit(encodeI(vsaPkg::opSw, 2'd0, vsaPkg::regIndex'(i + 1), vsaPkg::dataWord'(24 + i)));
    end
    runProgram();
    for (int i = 0; i < 3; i++) begin
        checkData($sformatf("copy of r%0d", i + 1), dataMem[24 + i], words[i]);
    end
    reportTest("load and store");
endtask

// two programs of four functions since all eight overflow the 16 slots
task automatic testAluFunctions();
    vsaPkg::dataWord  a;
    vsaPkg::dataWord  b;
    vsaPkg::dataWord  want;
    vsaPkg::funcField fn;
    for (int batch = 0; batch < 2; batch++) begin
        a = randomWord();
        b = randomWord();
        beginProgram();
        dataMem[1] = a;
        dataMem[2] = b;
        emit(encodeI(vsaPkg::opLw, 2'd0, 2'd1, 5'd1));
        emit(encodeI(vsaPkg::opLw, 2'd0, 2'd2, 5'd2));
        for (int k = 0; k < 4; k++) begin
            fn = vsaPkg::funcField'(batch * 4 + k);
            emit(encodeR(2'd1, 2'd2, 2'd3, fn));  // r3 = r1 op r2
            emit(encodeI(vsaPkg::opSw, 2'd0, 2'd3, vsaPkg::dataWord'(8 + k)));
        end
        runProgram();
        for (int k = 0; k < 4; k++) begin
            fn = vsaPkg::funcField'(batch * 4 + k);
            case (fn)
                vsaPkg::fnAdd: want = a + b;
                vsaPkg::fnSub: want = a - b;
                vsaPkg::fnAnd: want = a & b;
                vsaPkg::fnOr:  want = a | b;
                vsaPkg::fnXor: want = a ^ b;
                vsaPkg::fnNot: want = ~a;
                vsaPkg::fnSrl: want = a >> 1;
                default:       want = vsaPkg::dataWord'($signed(a) >>> 1);  // sra
            endcase
            checkData($sformatf("function %0d on %0d, %0d", fn, a, b), dataMem[8 + k], want);
        end
    end
    reportTest("register alu functions");
endtask

task automatic testImmediate();
    vsaPkg::dataWord a;
    vsaPkg::dataWord immAdd;
    vsaPkg::dataWord immSub;
    a      = randomWord();
    immAdd = randomWord();
    immSub = randomWord();
    beginProgram();
    dataMem[1] = a;
    emit(encodeI(vsaPkg::opLw, 2'd0, 2'd1, 5'd1));
    emit(encodeI(vsaPkg::opAddi, 2'd1, 2'd2, immAdd));
    emit(encodeI(vsaPkg::opSubi, 2'd1, 2'd3, immSub));
    emit(encodeI(vsaPkg::opSw, 2'd0, 2'd2, 5'd10));
    emit(encodeI(vsaPkg::opSw, 2'd0, 2'd3, 5'd11));
    runProgram();
    checkData("addi result", dataMem[10], a + immAdd);  // mod 32 by width
    checkData("subi result", dataMem[11], a - immSub);
    reportTest("immediate arithmetic");
endtask

task automatic testRegisterZero();
    beginProgram();
    dataMem[1]  = randomWord() | 5'd1;
    dataMem[12] = randomWord() | 5'd1;  // stale nonzero word to overwrite
    emit(encodeI(vsaPkg::opLw, 2'd0, 2'd1, 5'd1));
    emit(encodeI(vsaPkg::opAddi, 2'd1, 2'd0, 5'd7));
    emit(encodeR(2'd1, 2'd1, 2'd0, vsaPkg::fnAdd));
    emit(encodeI(vsaPkg::opLw, 2'd0, 2'd0, 5'd1));
    emit(encodeI(vsaPkg::opSw, 2'd0, 2'd0, 5'd12));
    runProgram();
    checkData("stored r0", dataMem[12], 5'd0);
    reportTest("register zero");
endtask

task automatic testBranch();
    vsaPkg::dataWord imm;
    imm = randomWord();
    if (imm[3:0] == 4'd0) begin
        imm[0] = 1'b1;  // keep target apart from fall-through
    end
    // taken case on r0 with the branch at 0 so npc is 2
    beginProgram();
    emit(encodeI(vsaPkg::opBeqz, 2'd0, 2'd0, imm));
    runProgram();
    checkPc("pc after taken beqz", pc, vsaPkg::pcWord'(2 + 2 * imm[3:0]));
    // not taken case with the branch at 2
    beginProgram();
    dataMem[1] = randomWord() | 5'd1;
    emit(encodeI(vsaPkg::opLw, 2'd0, 2'd1, 5'd1));
    emit(encodeI(vsaPkg::opBeqz, 2'd1, 2'd0, imm));
    runProgram();
    checkPc("pc after untaken beqz", pc, 5'd4);
    reportTest("branch");
endtask

task automatic testStrobeTiming();
    beginProgram();
    dataMem[1] = randomWord();
    emit(encodeI(vsaPkg::opLw, 2'd0, 2'd1, 5'd1));
    emit(encodeI(vsaPkg::opSw, 2'd0, 2'd1, 5'd15));  // the only store in the program
    emit(encodeI(vsaPkg::opAddi, 2'd1, 2'd2, 5'd3));
    emit(encodeR(2'd1, 2'd2, 2'd3, vsaPkg::fnXor));
    releaseCore();
    for (int c = 0; c < progLen * cyclesPerInstr; c++) begin
        @(negedge clock);  // mid cycle where outputs have settled
        checkStrobe($sformatf("wr in cycle %0d", c), wr, logic'(c == cyclesPerInstr + 3));
        // pc steps as phaseMem ends, so phaseWb already shows the next address
        checkPc($sformatf("pc in cycle %0d", c), pc,
                vsaPkg::pcWord'(2 * ((c + 1) / cyclesPerInstr)));
        @(posedge clock);
    end
    #driveDelay;
    checkData("stored word", dataMem[15], dataMem[1]);
    reportTest("write strobe timing");
endtask

`endif

// File: tests/vsaCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module vsaCoreTb;

    localparam int clockPeriod    = 100;  // ns
    localparam int resetCycles    = 16;
    localparam int driveDelay     = 10;   // inputs move this long after the rising edge
    localparam int cyclesPerInstr = 5;
    localparam int totalInstr     = 43;   // all programs added up
    localparam int numRuns        = 8;    // each program gets its own reset pulse
    // double the nominal run length, reset pulses included
    localparam int watchdogCycles =
        2 * (totalInstr * cyclesPerInstr + numRuns * (resetCycles + 2));

    logic             clock = 1'b0;
    logic             reset;
    vsaPkg::pcWord    pc;
    vsaPkg::instrWord instruction;
    vsaPkg::dataWord  aluOutput;
    vsaPkg::dataWord  dataIn;
    vsaPkg::dataWord  dataOut;
    logic             wr;

    vsaPkg::instrWord instrMem [32];  // indexed by pc, program at even addresses
    vsaPkg::dataWord  dataMem  [32];

    int progLen;         // instructions in the current program
    int errorCount;
    int lastErrorCount;  // errorCount when the previous test ended
    int testsRun;
    int testsFailed;

    vsaCore i_dut (
        .clock       (clock),
        .reset       (reset),
        .pc          (pc),
        .instruction (instruction),
        .aluOutput   (aluOutput),
        .dataIn      (dataIn),
        .dataOut     (dataOut),
        .wr          (wr)
    );

    // both memories answer within the phase
    assign instruction = instrMem[pc];
    assign dataIn      = dataMem[aluOutput];

    // store lands on the edge that closes phaseMem
    always @(posedge clock) begin
        if (wr) begin
            dataMem[aluOutput] <= dataOut;
        end
    end

    always #(clockPeriod / 2) clock = ~clock;

    `include "vsaTestTasks.svh"

    // stuck core or lost edge
    initial begin
        repeat (watchdogCycles) @(posedge clock);
        $display("timeout: the tests did not finish within %0d clock cycles", watchdogCycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        reset          = 1'b1;
        progLen        = 0;
        errorCount     = 0;
        lastErrorCount = 0;
        testsRun       = 0;
        testsFailed    = 0;
        void'($urandom(68));  // single seed for the whole run
        clearMemories();

        testLoadStore();
        testAluFunctions();
        testImmediate();
        testRegisterZero();
        testBranch();
        testStrobeTiming();

        $display("tests run %0d, failed %0d, mismatches %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+tests
hw/vsaPkg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/vsaCore.sv
tests/vsaCoreTb.sv

// File: Bender.yml
package:
  name: vsa_core

sources:
  - hw/vsaPkg.sv
  - hw/fetchStage.sv
  - hw/decodeStage.sv
  - hw/executeStage.sv
  - hw/memoryStage.sv
  - hw/vsaCore.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/vsaCoreTb.sv
